// ==== renameRetire.f ====
logic/rrPkg.sv
logic/reorderBuffer.sv
logic/freeList.sv
logic/mapTable.sv
logic/archMapTable.sv
logic/renameRetireTop.sv
testbench/renameRetire_assert.sv
testbench/renameRetireChecker.sv
testbench/renameRetireTb.sv

// ==== runSim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module renameRetireTb \
  -f renameRetire.f \
  -o simRenameRetire

./obj_dir/simRenameRetire > sim.log 2>&1
cat sim.log

if grep -q "Done: errors found" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

// ==== testbench/renameRetireTb.sv ====
`timescale 1ns/1ps

module renameRetireTb import rrPkg::*; ();

  localparam int numSteps = 24;
  localparam int drainLimit = 200;

  typedef struct packed {
    robIdxT idx;
    archRegT dest;
    physTagT newTag;
    physTagT oldTag;
    logic halt;
    logic complete;
  } modelEntryT;

  logic clock, reset, dispatchEn, rollbackEn;
  dispatchPairT dispatchIn;
  completeBusT completeIn;
  robIdxT rollbackIdx, dispatchIdx;
  logic dispatchAccept, halt, robReady;
  renamePairT renameOut;
  retirePairT retireOut;

  // stimulus table
  logic stepEn [numSteps];
  dispatchPairT stepPair [numSteps];
  completeBusT stepComplete [numSteps];
  logic stepRollback [numSteps];
  robIdxT stepRollbackIdx [numSteps];

  // reference model
  physMaskT freeMask;
  physTagT specMap [numArch];
  physTagT archMap [numArch];
  modelEntryT robQ [$];
  robIdxT modelTail, branchIdx;
  logic draining;

  logic checkEn = 1'b0;
  logic expAccept, expHalt, expReady;
  robIdxT expIdx;
  renamePairT expRename;
  retirePairT expRetire;
  integer seed = 95;
  int timeoutErrors = 0;
  int waitCount, total, n;
  completeBusT drainBus;

  renameRetireTop UUT (
    .clock(clock), .reset(reset), .dispatchEn(dispatchEn), .dispatchIn(dispatchIn),
    .completeIn(completeIn), .rollbackEn(rollbackEn), .rollbackIdx(rollbackIdx),
    .dispatchAccept(dispatchAccept), .dispatchIdx(dispatchIdx), .renameOut(renameOut),
    .retireOut(retireOut), .halt(halt), .robReady(robReady)
  );

  renameRetireChecker scoreboard (
    .clock(clock), .checkEn(checkEn), .dispatchAccept(dispatchAccept),
    .dispatchIdx(dispatchIdx), .renameOut(renameOut), .retireOut(retireOut),
    .halt(halt), .robReady(robReady), .expAccept(expAccept), .expIdx(expIdx),
    .expRename(expRename), .expRetire(expRetire), .expHalt(expHalt), .expReady(expReady)
  );

  always #20 clock = ~clock;

  function automatic completeBusT makeComplete(int a, int b);
    completeBusT bus;
    bus.en = 2'b11;
    bus.idx[0] = robIdxT'(a);
    bus.idx[1] = robIdxT'(b);
    return bus;
  endfunction

  function automatic int findPos(robIdxT idx);
    for (int p = 0; p < robQ.size(); p++) begin
      if (robQ[p].idx == idx) begin
        return p;
      end
    end
    return -1;
  endfunction

  task automatic buildTable();
    for (int i = 0; i < numSteps; i++) begin
      stepEn[i] = 1'b1;
      stepPair[i].dest[0] = archRegT'($random(seed));
      stepPair[i].dest[1] = archRegT'($random(seed));
      stepPair[i].halt = 2'b00;
      stepPair[i].writesReg = 2'b11;
      stepComplete[i] = '0;
      stepRollback[i] = 1'b0;
      stepRollbackIdx[i] = '0;
    end
    stepPair[2].dest[1] = stepPair[2].dest[0];
    stepPair[5].halt = 2'b10;
    stepPair[19].halt = 2'b01;
    // buffer and tags run out at step 8, so the pair is held until tags return
    stepPair[9] = stepPair[8];
    stepPair[10] = stepPair[8];
    stepPair[11] = stepPair[8];
    stepPair[12] = stepPair[8];
    stepComplete[8] = makeComplete(5, 3);
    stepComplete[9] = makeComplete(1, 4);
    stepComplete[10] = makeComplete(0, 2);
    stepComplete[11] = makeComplete(6, 7);
    stepComplete[12] = makeComplete(8, 9);
    stepComplete[13] = makeComplete(10, 11);
    stepEn[14] = 1'b0;
    stepRollback[14] = 1'b1;
    stepRollbackIdx[14] = robIdxT'(12);
    stepComplete[14] = makeComplete(12, 13);
    stepComplete[15] = makeComplete(14, 15);
    stepComplete[20] = makeComplete(1, 0);
    stepComplete[22] = makeComplete(2, 3);
  endtask

  task automatic modelReset();
    freeMask = resetFreeMask;
    for (int r = 0; r < numArch; r++) begin
      specMap[r] = physTagT'(r);
      archMap[r] = physTagT'(r);
    end
    robQ.delete();
    modelTail = '0;
    branchIdx = '0;
    draining = 1'b0;
  endtask

  task automatic modelStep();
    int nRet;
    int pos;
    int found;
    logic mis, drainNow, rec;
    robIdxT active;
    physTagT pick0, pick1;
    physMaskT cmask;
    modelEntryT entry;
    nRet = 0;
    found = 0;
    rec = 1'b0;
    pick0 = '0;
    pick1 = '0;
    pos = findPos(rollbackIdx);
    mis = rollbackEn && (pos >= 0);
    active = mis ? rollbackIdx : branchIdx;
    drainNow = draining || mis;
    if (robQ.size() > 0 && robQ[0].complete) begin
      nRet = 1;
    end
    // nothing younger leaves together with the mispredicted branch
    if (nRet == 1 && robQ.size() > 1 && robQ[1].complete &&
        !(drainNow && robQ[0].idx == active)) begin
      nRet = 2;
    end
    expRetire = '0;
    for (int k = 0; k < nRet; k++) begin
      expRetire.valid[k] = 1'b1;
      expRetire.dest[k] = robQ[k].dest;
      expRetire.newTag[k] = robQ[k].newTag;
      expRetire.oldTag[k] = robQ[k].oldTag;
      expRetire.halt[k] = robQ[k].halt;
      if (drainNow && robQ[k].idx == active) begin
        rec = 1'b1;
      end
    end
    expHalt = |expRetire.halt;
    expReady = !draining && !rollbackEn;
    for (int i = 0; i < numPhys; i++) begin
      if (freeMask[i] && found == 1) begin
        pick1 = physTagT'(i);
        found = 2;
      end else if (freeMask[i] && found == 0) begin
        pick0 = physTagT'(i);
        found = 1;
      end
    end
    expAccept = dispatchEn && (robQ.size() - nRet <= numRob - 2) && (found == 2) && expReady;
    expIdx = modelTail;
    expRename.newTag[0] = pick0;
    expRename.newTag[1] = pick1;
    expRename.oldTag[0] = specMap[dispatchIn.dest[0]];
    expRename.oldTag[1] = (dispatchIn.dest[1] == dispatchIn.dest[0]) ?
                          pick0 : specMap[dispatchIn.dest[1]];

    // advance to the state after this edge
    for (int s = 0; s < numSuper; s++) begin
      if (completeIn.en[s] && findPos(completeIn.idx[s]) >= 0) begin
        robQ[findPos(completeIn.idx[s])].complete = 1'b1;
      end
    end
    if (dispatchAccept) begin
      freeMask[pick0] = 1'b0;
      freeMask[pick1] = 1'b0;
      specMap[dispatchIn.dest[0]] = pick0;
      specMap[dispatchIn.dest[1]] = pick1;
    end
    for (int k = 0; k < nRet; k++) begin
      archMap[robQ[0].dest] = robQ[0].newTag;
      freeMask[robQ[0].oldTag] = 1'b1;
      void'(robQ.pop_front());
    end
    if (dispatchAccept) begin
      for (int s = 0; s < numSuper; s++) begin
        entry.idx = modelTail + robIdxT'(s);
        entry.dest = dispatchIn.dest[s];
        entry.newTag = expRename.newTag[s];
        entry.oldTag = expRename.oldTag[s];
        entry.halt = dispatchIn.halt[s];
        entry.complete = 1'b0;
        robQ.push_back(entry);
      end
      modelTail = modelTail + robIdxT'(2);
    end
    if (mis) begin
      pos = findPos(rollbackIdx);
      while (robQ.size() > pos + 1) begin
        void'(robQ.pop_back());
      end
      modelTail = rollbackIdx + robIdxT'(1);
    end
    if (rec) begin
      cmask = '0;
      for (int r = 0; r < numArch; r++) begin
        cmask[archMap[r]] = 1'b1;
        specMap[r] = archMap[r];
      end
      freeMask = ~cmask;
      draining = 1'b0;
    end else if (mis) begin
      draining = 1'b1;
    end
    branchIdx = active;
  endtask

  always @(negedge clock) begin
    if (reset) begin
      modelReset();
    end else begin
      modelStep();
      checkEn = 1'b1;
    end
  end

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    dispatchEn = 1'b0;
    dispatchIn = '0;
    completeIn = '0;
    rollbackEn = 1'b0;
    rollbackIdx = '0;
    buildTable();
    repeat (4) @(posedge clock);
    reset <= 1'b0;
    for (int i = 0; i < numSteps; i++) begin
      @(posedge clock);
      dispatchEn <= stepEn[i];
      dispatchIn <= stepPair[i];
      completeIn <= stepComplete[i];
      rollbackEn <= stepRollback[i];
      rollbackIdx <= stepRollbackIdx[i];
    end
    // complete whatever is still in flight until the buffer is empty
    waitCount = 0;
    while ((robQ.size() != 0 || draining) && waitCount < drainLimit) begin
      @(posedge clock);
      drainBus = '0;
      n = 0;
      for (int p = 0; p < robQ.size(); p++) begin
        if (!robQ[p].complete && n < 2) begin
          drainBus.en[n] = 1'b1;
          drainBus.idx[n] = robQ[p].idx;
          n++;
        end
      end
      dispatchEn <= 1'b0;
      rollbackEn <= 1'b0;
      completeIn <= drainBus;
      waitCount++;
    end
    if (robQ.size() != 0 || draining) begin
      timeoutErrors++;
      $display("timeout: the reorder buffer did not drain within %0d cycles", drainLimit);
    end
    @(posedge clock);
    completeIn <= '0;
    repeat (2) @(posedge clock);
    total = scoreboard.errorCount + timeoutErrors;
    $display("checks finished with %0d errors", total);
    if (total == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== testbench/renameRetireChecker.sv ====
`timescale 1ns/1ps

module renameRetireChecker import rrPkg::*; (
  input logic       clock,
  input logic       checkEn,
  input logic       dispatchAccept,
  input robIdxT     dispatchIdx,
  input renamePairT renameOut,
  input retirePairT retireOut,
  input logic       halt,
  input logic       robReady,
  input logic       expAccept,
  input robIdxT     expIdx,
  input renamePairT expRename,
  input retirePairT expRetire,
  input logic       expHalt,
  input logic       expReady
);

  int errorCount = 0;

  task automatic compareValue(string name, logic [63:0] actual, logic [63:0] expected);
    if (actual !== expected) begin
      errorCount++;
      $display("FAILED %s: got 0x%0h expected 0x%0h at %0t", name, actual, expected, $time);
    end
  endtask

  // outputs are sampled just before the edge that consumes them
  always @(posedge clock) begin
    if (checkEn) begin
      compareValue("dispatchAccept", 64'(dispatchAccept), 64'(expAccept));
      compareValue("robReady", 64'(robReady), 64'(expReady));
      compareValue("halt", 64'(halt), 64'(expHalt));
      compareValue("retireOut.valid", 64'(retireOut.valid), 64'(expRetire.valid));
      if (expAccept && dispatchAccept) begin
        compareValue("dispatchIdx", 64'(dispatchIdx), 64'(expIdx));
        compareValue("renameOut.newTag", 64'(renameOut.newTag), 64'(expRename.newTag));
        compareValue("renameOut.oldTag", 64'(renameOut.oldTag), 64'(expRename.oldTag));
      end
      for (int s = 0; s < numSuper; s++) begin
        if (expRetire.valid[s] && retireOut.valid[s]) begin
          compareValue($sformatf("retireOut.dest[%0d]", s),
                       64'(retireOut.dest[s]), 64'(expRetire.dest[s]));
          compareValue($sformatf("retireOut.newTag[%0d]", s),
                       64'(retireOut.newTag[s]), 64'(expRetire.newTag[s]));
          compareValue($sformatf("retireOut.oldTag[%0d]", s),
                       64'(retireOut.oldTag[s]), 64'(expRetire.oldTag[s]));
          compareValue($sformatf("retireOut.halt[%0d]", s),
                       64'(retireOut.halt[s]), 64'(expRetire.halt[s]));
        end
      end
    end
  end

endmodule

// ==== testbench/renameRetire_assert.sv ====
`timescale 1ns/1ps

module robAssertions import rrPkg::*; (
  input logic       clock,
  input logic       reset,
  input retirePairT retireOut,
  input logic       dispatchAccept,
  input logic       robReady,
  input logic       recover
);

  // retire is strictly in order
  assert property (@(posedge clock) disable iff (reset)
    retireOut.valid[1] |-> retireOut.valid[0])
    else $error("slot 1 retired without slot 0");

  assert property (@(posedge clock) disable iff (reset)
    dispatchAccept |-> robReady)
    else $error("dispatch accepted while the reorder buffer was not ready");

  assert property (@(posedge clock) disable iff (reset)
    recover |=> !recover)
    else $error("recover held for more than one cycle");

endmodule

bind reorderBuffer robAssertions robChecks (
  .clock(clock),
  .reset(reset),
  .retireOut(retireOut),
  .dispatchAccept(dispatchAccept),
  .robReady(robReady),
  .recover(recover)
);

// ==== logic/renameRetireTop.sv ====
`timescale 1ns/1ps

module renameRetireTop import rrPkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         dispatchEn,
  input  dispatchPairT dispatchIn,
  input  completeBusT  completeIn,
  input  logic         rollbackEn,
  input  robIdxT       rollbackIdx,
  output logic         dispatchAccept,
  output robIdxT       dispatchIdx,
  output renamePairT   renameOut,
  output retirePairT   retireOut,
  output logic         halt,
  output logic         robReady
);

  logic tagsAvailable;
  logic recover;
  physTagT [numSuper-1:0] newTags;
  physTagT [numSuper-1:0] oldTags;
  archMapT committedMap;
  physMaskT committedMask;

  assign renameOut.newTag = newTags;
  assign renameOut.oldTag = oldTags;

  reorderBuffer rob (
    .clock(clock),
    .reset(reset),
    .dispatchEn(dispatchEn),
    .dispatchIn(dispatchIn),
    .tagsAvailable(tagsAvailable),
    .newTags(newTags),
    .oldTags(oldTags),
    .completeIn(completeIn),
    .rollbackEn(rollbackEn),
    .rollbackIdx(rollbackIdx),
    .dispatchAccept(dispatchAccept),
    .dispatchIdx(dispatchIdx),
    .retireOut(retireOut),
    .halt(halt),
    .robReady(robReady),
    .recover(recover)
  );

  freeList freeTags (
    .clock(clock),
    .reset(reset),
    .dispatchAccept(dispatchAccept),
    .retireOut(retireOut),
    .recover(recover),
    .committedMask(committedMask),
    .newTags(newTags),
    .tagsAvailable(tagsAvailable)
  );

  mapTable specMapTable (
    .clock(clock),
    .reset(reset),
    .dispatchAccept(dispatchAccept),
    .dispatchIn(dispatchIn),
    .newTags(newTags),
    .recover(recover),
    .committedMap(committedMap),
    .oldTags(oldTags)
  );

  archMapTable commitMapTable (
    .clock(clock),
    .reset(reset),
    .retireOut(retireOut),
    .committedMap(committedMap),
    .committedMask(committedMask)
  );

endmodule

// ==== logic/archMapTable.sv ====
`timescale 1ns/1ps

module archMapTable import rrPkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  retirePairT retireOut,
  output archMapT    committedMap,
  output physMaskT   committedMask
);

  archMapT archMap, archNext;

  // equal new and old tag marks a slot that writes no register
  always_comb begin
    archNext = archMap;
    for (int s = 0; s < numSuper; s++) begin
      if (retireOut.valid[s] && (retireOut.newTag[s] != retireOut.oldTag[s])) begin
        archNext[retireOut.dest[s]] = retireOut.newTag[s];
      end
    end
  end

  // map as it stands after this cycle's retirement
  // so a recover on the branch's own retire sees the branch's write
  assign committedMap = archNext;

  always_comb begin
    committedMask = '0;
    for (int r = 0; r < numArch; r++) begin
      committedMask[committedMap[r]] = 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      archMap <= identityMap;
    end else begin
      archMap <= archNext;
    end
  end

endmodule

// ==== logic/mapTable.sv ====
`timescale 1ns/1ps

module mapTable import rrPkg::*; (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   dispatchAccept,
  input  dispatchPairT           dispatchIn,
  input  physTagT [numSuper-1:0] newTags,
  input  logic                   recover,
  input  archMapT                committedMap,
  output physTagT [numSuper-1:0] oldTags
);

  archMapT specMap;
  logic sameDest;

  assign sameDest = dispatchIn.writesReg[0] && (dispatchIn.dest[0] == dispatchIn.dest[1]);

  // a slot without a destination hands back its own tag as the one to free at retire
  always_comb begin
    if (dispatchIn.writesReg[0]) begin
      oldTags[0] = specMap[dispatchIn.dest[0]];
    end else begin
      oldTags[0] = newTags[0];
    end
    if (!dispatchIn.writesReg[1]) begin
      oldTags[1] = newTags[1];
    end else if (sameDest) begin
      // slot 0 renamed the same register one step earlier
      oldTags[1] = newTags[0];
    end else begin
      oldTags[1] = specMap[dispatchIn.dest[1]];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      specMap <= identityMap;
    end else if (recover) begin
      specMap <= committedMap;
    end else if (dispatchAccept) begin
      if (dispatchIn.writesReg[0]) begin
        specMap[dispatchIn.dest[0]] <= newTags[0];
      end
      // slot 1 is younger and lands last
      if (dispatchIn.writesReg[1]) begin
        specMap[dispatchIn.dest[1]] <= newTags[1];
      end
    end
  end

endmodule

// ==== logic/freeList.sv ====
`timescale 1ns/1ps

module freeList import rrPkg::*; (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   dispatchAccept,
  input  retirePairT             retireOut,
  input  logic                   recover,
  input  physMaskT               committedMask,
  output physTagT [numSuper-1:0] newTags,
  output logic                   tagsAvailable
);

  physMaskT freeMask, freeNext;
  physTagT pick0, pick1;
  logic found0, found1;

  // two lowest free tags, slot 0 gets the lower one
  always_comb begin
    found0 = 1'b0;
    found1 = 1'b0;
    pick0 = '0;
    pick1 = '0;
    for (int i = 0; i < numPhys; i++) begin
      if (freeMask[i]) begin
        if (!found0) begin
          pick0 = physTagT'(i);
          found0 = 1'b1;
        end else if (!found1) begin
          pick1 = physTagT'(i);
          found1 = 1'b1;
        end
      end
    end
  end

  assign newTags[0] = pick0;
  assign newTags[1] = pick1;
  assign tagsAvailable = found0 && found1;

  always_comb begin
    freeNext = freeMask;
    if (dispatchAccept) begin
      freeNext[pick0] = 1'b0;
      freeNext[pick1] = 1'b0;
    end
    // old tags of retiring entries come back
    for (int s = 0; s < numSuper; s++) begin
      if (retireOut.valid[s]) begin
        freeNext[retireOut.oldTag[s]] = 1'b1;
      end
    end
    // rebuild from what the committed map does not hold
    if (recover) begin
      freeNext = ~committedMask;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      freeMask <= resetFreeMask;
    end else begin
      freeMask <= freeNext;
    end
  end

endmodule

// ==== logic/reorderBuffer.sv ====
`timescale 1ns/1ps

module reorderBuffer import rrPkg::*; (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   dispatchEn,
  input  dispatchPairT           dispatchIn,
  input  logic                   tagsAvailable,
  input  physTagT [numSuper-1:0] newTags,
  input  physTagT [numSuper-1:0] oldTags,
  input  completeBusT            completeIn,
  input  logic                   rollbackEn,
  input  robIdxT                 rollbackIdx,
  output logic                   dispatchAccept,
  output robIdxT                 dispatchIdx,
  output retirePairT             retireOut,
  output logic                   halt,
  output logic                   robReady,
  output logic                   recover
);

  typedef enum logic {robRunning, robDraining} robStateT;

  typedef struct packed {
    logic halt;
    archRegT dest;
    physTagT newTag;
    physTagT oldTag;
  } robEntryT;

  robStateT state, stateNext;
  robIdxT head, tail, headPlusOne, tailPlusOne, headNext, tailNext;
  robIdxT branchIdx, activeBranch, tailOffset;
  logic [numRob-1:0] entryValid, entryComplete, validNext, completeNext, squashMask;
  robEntryT entryData [numRob];
  logic [numSuper-1:0] retireEn;
  logic tailFree, tailPlusOneFree;
  logic mispredict, drainingNow, branchRetiring;

  assign headPlusOne = head + robIdxT'(1);
  assign tailPlusOne = tail + robIdxT'(1);
  assign dispatchIdx = tail;

  // a rollback only counts when it names a live entry
  assign mispredict = rollbackEn && entryValid[rollbackIdx];
  assign drainingNow = (state == robDraining) || mispredict;
  assign activeBranch = mispredict ? rollbackIdx : branchIdx;

  // in-order retire from the head
  always_comb begin
    retireEn[0] = entryValid[head] && entryComplete[head];
    // nothing behind a mispredicted branch may leave alongside it
    retireEn[1] = retireEn[0] && entryValid[headPlusOne] && entryComplete[headPlusOne] &&
                  !(drainingNow && (head == activeBranch));
  end

  always_comb begin
    retireOut.valid = retireEn;
    retireOut.dest[0] = entryData[head].dest;
    retireOut.dest[1] = entryData[headPlusOne].dest;
    retireOut.newTag[0] = entryData[head].newTag;
    retireOut.newTag[1] = entryData[headPlusOne].newTag;
    retireOut.oldTag[0] = entryData[head].oldTag;
    retireOut.oldTag[1] = entryData[headPlusOne].oldTag;
    retireOut.halt[0] = retireEn[0] && entryData[head].halt;
    retireOut.halt[1] = retireEn[1] && entryData[headPlusOne].halt;
  end

  assign halt = |retireOut.halt;

  assign branchRetiring = (retireEn[0] && (head == activeBranch)) ||
                          (retireEn[1] && (headPlusOne == activeBranch));
  assign recover = drainingNow && branchRetiring;

  // an entry leaving at the head this cycle can be refilled at once
  assign tailFree = !entryValid[tail] || (retireEn[0] && (tail == head)) ||
                    (retireEn[1] && (tail == headPlusOne));
  assign tailPlusOneFree = !entryValid[tailPlusOne] || (retireEn[0] && (tailPlusOne == head)) ||
                           (retireEn[1] && (tailPlusOne == headPlusOne));

  assign robReady = (state == robRunning) && !rollbackEn;
  assign dispatchAccept = dispatchEn && tailFree && tailPlusOneFree && tagsAvailable && robReady;

  // distance from the branch, so the squash range wraps naturally
  assign tailOffset = tail - rollbackIdx;

  for (genvar i = 0; i < numRob; i++) begin : genSquash
    robIdxT offset;
    assign offset = robIdxT'(i) - rollbackIdx;
    // tail sitting on the branch means the buffer is full and all others are younger
    assign squashMask[i] = (offset != '0) && ((offset < tailOffset) || (tailOffset == '0));
  end

  always_comb begin
    validNext = entryValid;
    completeNext = entryComplete;
    for (int s = 0; s < numSuper; s++) begin
      if (completeIn.en[s]) begin
        completeNext[completeIn.idx[s]] = 1'b1;
      end
    end
    if (retireEn[0]) begin
      validNext[head] = 1'b0;
    end
    if (retireEn[1]) begin
      validNext[headPlusOne] = 1'b0;
    end
    // new pair overrides an entry freed this same cycle
    if (dispatchAccept) begin
      validNext[tail] = 1'b1;
      validNext[tailPlusOne] = 1'b1;
      completeNext[tail] = 1'b0;
      completeNext[tailPlusOne] = 1'b0;
    end
    if (mispredict) begin
      validNext = validNext & ~squashMask;
    end
  end

  always_comb begin
    case ({retireEn[1], retireEn[0]})
      2'b11: headNext = head + robIdxT'(2);
      2'b01: headNext = headPlusOne;
      default: headNext = head;
    endcase
    if (mispredict) begin
      tailNext = rollbackIdx + robIdxT'(1);
    end else if (dispatchAccept) begin
      tailNext = tail + robIdxT'(2);
    end else begin
      tailNext = tail;
    end
  end

  // branch retiring in its own rollback cycle never enters draining
  always_comb begin
    case (state)
      robRunning: stateNext = (mispredict && !recover) ? robDraining : robRunning;
      robDraining: stateNext = recover ? robRunning : robDraining;
      default: stateNext = robRunning;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= robRunning;
      head <= '0;
      tail <= '0;
      branchIdx <= '0;
      entryValid <= '0;
      entryComplete <= '0;
    end else begin
      state <= stateNext;
      head <= headNext;
      tail <= tailNext;
      branchIdx <= activeBranch;
      entryValid <= validNext;
      entryComplete <= completeNext;
    end
  end

  // payload written on accept only
  always_ff @(posedge clock) begin
    if (dispatchAccept) begin
      entryData[tail] <= '{halt: dispatchIn.halt[0], dest: dispatchIn.dest[0],
                           newTag: newTags[0], oldTag: oldTags[0]};
      entryData[tailPlusOne] <= '{halt: dispatchIn.halt[1], dest: dispatchIn.dest[1],
                                  newTag: newTags[1], oldTag: oldTags[1]};
    end
  end

endmodule

// ==== logic/rrPkg.sv ====
package rrPkg;

  // machine sizes
  localparam int numSuper = 2;
  localparam int numRob = 16;
  localparam int numArch = 32;
  localparam int numPhys = 48;

  typedef logic [$clog2(numRob)-1:0] robIdxT;
  typedef logic [$clog2(numArch)-1:0] archRegT;
  typedef logic [$clog2(numPhys)-1:0] physTagT;
  typedef physTagT [numArch-1:0] archMapT;
  typedef logic [numPhys-1:0] physMaskT;

  // one dispatch group as it arrives from decode
  typedef struct packed {
    archRegT [numSuper-1:0] dest;
    logic [numSuper-1:0] halt;
    logic [numSuper-1:0] writesReg;
  } dispatchPairT;

  typedef struct packed {
    physTagT [numSuper-1:0] newTag;
    physTagT [numSuper-1:0] oldTag;
  } renamePairT;

  // slot 0 is always the older of the two retiring entries
  typedef struct packed {
    logic [numSuper-1:0] valid;
    archRegT [numSuper-1:0] dest;
    physTagT [numSuper-1:0] newTag;
    physTagT [numSuper-1:0] oldTag;
    logic [numSuper-1:0] halt;
  } retirePairT;

  typedef struct packed {
    logic [numSuper-1:0] en;
    robIdxT [numSuper-1:0] idx;
  } completeBusT;

  function automatic archMapT buildIdentityMap();
    archMapT map;
    for (int i = 0; i < numArch; i++) begin
      map[i] = physTagT'(i);
    end
    return map;
  endfunction

  // register i sits in tag i out of reset
  localparam archMapT identityMap = buildIdentityMap();
  // tags above the architectural range start out free
  localparam physMaskT resetFreeMask = {{(numPhys - numArch){1'b1}}, {numArch{1'b0}}};

endpackage
